// File: Bender.yml
package:
  name: core_backend

sources:
  - src/backend_pkg.sv
  - src/scoreboard.sv
  - src/issue_queue.sv
  - src/prf.sv
  - src/alu_pipe.sv
  - src/mul_pipe.sv
  - src/core_backend.sv
  - target: test
    files:
      - testbench/result_checker.sv
      - testbench/tb_core_backend.sv

// File: src/alu_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu pipe
// single-cycle li, add, sub, and, or and xor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module alu_pipe (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    issue_valid,
  input  backend_pkg::op_t                        op,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] rd,
  input  logic [backend_pkg::DATA_WIDTH-1:0]      imm,
  input  logic [backend_pkg::TAG_WIDTH-1:0]       tag,
  input  logic [backend_pkg::DATA_WIDTH-1:0]      src1,
  input  logic [backend_pkg::DATA_WIDTH-1:0]      src2,
  output logic                                    out_valid,
  output logic [backend_pkg::PRF_INDEX_WIDTH-1:0] out_rd,
  output logic [backend_pkg::TAG_WIDTH-1:0]       out_tag,
  output logic [backend_pkg::DATA_WIDTH-1:0]      out_data
);

  logic [backend_pkg::DATA_WIDTH-1:0] result;

  always_comb begin
    case (op)
      backend_pkg::li:     result = imm;
      backend_pkg::add:    result = src1 + src2;
      backend_pkg::sub:    result = src1 - src2;
      backend_pkg::and_op: result = src1 & src2;
      backend_pkg::or_op:  result = src1 | src2;
      backend_pkg::xor_op: result = src1 ^ src2;
      default:             result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= issue_valid;
    end
  end

  // payload registers beside the valid
  always_ff @(posedge clock) begin
    out_rd   <= rd;
    out_tag  <= tag;
    out_data <= result;
  end

endmodule

// File: src/backend_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// backend package
// op encoding, word and register-file sizes shared
// by the issue, register and execution blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package backend_pkg;

  localparam int DATA_WIDTH = 32;
  localparam int PRF_SIZE = 32;
  localparam int PRF_INDEX_WIDTH = $clog2(PRF_SIZE);
  localparam int TAG_WIDTH = 5;

  // micro-op operations with values fixed by the pattern file
  typedef enum logic [2:0] {
    li     = 3'd0,
    add    = 3'd1,
    sub    = 3'd2,
    and_op = 3'd3,
    or_op  = 3'd4,
    xor_op = 3'd5,
    mul    = 3'd6
  } op_t;

  // true for ops that go to the multiply pipe
  function automatic logic is_mul_op(input op_t op);
    return (op == mul);
  endfunction

endpackage

// File: src/core_backend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core back end
// dispatch, issue queue, scoreboard, register file
// and the alu and multiply pipes with writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module core_backend #(
  parameter int IQ_DEPTH = 8,
  parameter int MUL_STAGES = 3
) (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    dispatch_req,
  input  backend_pkg::op_t                        dispatch_op,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] dispatch_rs1,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] dispatch_rs2,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] dispatch_rd,
  input  logic [backend_pkg::DATA_WIDTH-1:0]      dispatch_imm,
  input  logic [backend_pkg::TAG_WIDTH-1:0]       dispatch_tag,
  output logic                                    dispatch_ack,
  output logic                                    result_alu_valid,
  output logic [backend_pkg::TAG_WIDTH-1:0]       result_alu_tag,
  output logic [backend_pkg::DATA_WIDTH-1:0]      result_alu_data,
  output logic                                    result_mul_valid,
  output logic [backend_pkg::TAG_WIDTH-1:0]       result_mul_tag,
  output logic [backend_pkg::DATA_WIDTH-1:0]      result_mul_data
);

  logic                                    set_valid;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] set_index;
  logic [backend_pkg::PRF_SIZE-1:0]        busy_vector;
  logic                                    alu_issue_valid;
  backend_pkg::op_t                        alu_op;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] alu_rd;
  logic [backend_pkg::DATA_WIDTH-1:0]      alu_imm;
  logic [backend_pkg::TAG_WIDTH-1:0]       alu_tag;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] alu_rs1_index;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] alu_rs2_index;
  logic                                    mul_issue_valid;
  backend_pkg::op_t                        mul_op;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] mul_rd;
  logic [backend_pkg::TAG_WIDTH-1:0]       mul_tag;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] mul_rs1_index;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] mul_rs2_index;
  logic [backend_pkg::DATA_WIDTH-1:0]      rd_data_a1;
  logic [backend_pkg::DATA_WIDTH-1:0]      rd_data_a2;
  logic [backend_pkg::DATA_WIDTH-1:0]      rd_data_m1;
  logic [backend_pkg::DATA_WIDTH-1:0]      rd_data_m2;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] alu_out_rd;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] mul_out_rd;

  issue_queue #(.IQ_DEPTH(IQ_DEPTH)) u_issue_queue (
    .clock           (clock),
    .reset           (reset),
    .dispatch_req    (dispatch_req),
    .dispatch_op     (dispatch_op),
    .dispatch_rs1    (dispatch_rs1),
    .dispatch_rs2    (dispatch_rs2),
    .dispatch_rd     (dispatch_rd),
    .dispatch_imm    (dispatch_imm),
    .dispatch_tag    (dispatch_tag),
    .dispatch_ack    (dispatch_ack),
    .set_valid       (set_valid),
    .set_index       (set_index),
    .busy_vector     (busy_vector),
    .alu_issue_valid (alu_issue_valid),
    .alu_op          (alu_op),
    .alu_rd          (alu_rd),
    .alu_imm         (alu_imm),
    .alu_tag         (alu_tag),
    .alu_rs1_index   (alu_rs1_index),
    .alu_rs2_index   (alu_rs2_index),
    .mul_issue_valid (mul_issue_valid),
    .mul_op          (mul_op),
    .mul_rd          (mul_rd),
    .mul_tag         (mul_tag),
    .mul_rs1_index   (mul_rs1_index),
    .mul_rs2_index   (mul_rs2_index)
  );

  // writeback port 0 is the alu, port 1 the multiplier
  scoreboard u_scoreboard (
    .clock       (clock),
    .reset       (reset),
    .set_valid   (set_valid),
    .set_index   (set_index),
    .clear_valid ({result_mul_valid, result_alu_valid}),
    .clear_index ({mul_out_rd, alu_out_rd}),
    .busy_vector (busy_vector)
  );

  prf u_prf (
    .clock       (clock),
    .reset       (reset),
    .rd_index_a1 (alu_rs1_index),
    .rd_index_a2 (alu_rs2_index),
    .rd_index_m1 (mul_rs1_index),
    .rd_index_m2 (mul_rs2_index),
    .rd_data_a1  (rd_data_a1),
    .rd_data_a2  (rd_data_a2),
    .rd_data_m1  (rd_data_m1),
    .rd_data_m2  (rd_data_m2),
    .wr_en       ({result_mul_valid, result_alu_valid}),
    .wr_index    ({mul_out_rd, alu_out_rd}),
    .wr_data     ({result_mul_data, result_alu_data})
  );

  alu_pipe u_alu_pipe (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (alu_issue_valid),
    .op          (alu_op),
    .rd          (alu_rd),
    .imm         (alu_imm),
    .tag         (alu_tag),
    .src1        (rd_data_a1),
    .src2        (rd_data_a2),
    .out_valid   (result_alu_valid),
    .out_rd      (alu_out_rd),
    .out_tag     (result_alu_tag),
    .out_data    (result_alu_data)
  );

  mul_pipe #(.MUL_STAGES(MUL_STAGES)) u_mul_pipe (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (mul_issue_valid),
    .op          (mul_op),
    .rd          (mul_rd),
    .tag         (mul_tag),
    .src1        (rd_data_m1),
    .src2        (rd_data_m2),
    .out_valid   (result_mul_valid),
    .out_rd      (mul_out_rd),
    .out_tag     (result_mul_tag),
    .out_data    (result_mul_data)
  );

endmodule

// File: src/issue_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue queue
// four-phase dispatch port, age-ordered slots and
// oldest-ready select for the alu and multiply pipes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module issue_queue #(
  parameter int IQ_DEPTH = 8
) (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    dispatch_req,
  input  backend_pkg::op_t                        dispatch_op,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] dispatch_rs1,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] dispatch_rs2,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] dispatch_rd,
  input  logic [backend_pkg::DATA_WIDTH-1:0]      dispatch_imm,
  input  logic [backend_pkg::TAG_WIDTH-1:0]       dispatch_tag,
  output logic                                    dispatch_ack,
  output logic                                    set_valid,
  output logic [backend_pkg::PRF_INDEX_WIDTH-1:0] set_index,
  input  logic [backend_pkg::PRF_SIZE-1:0]        busy_vector,
  output logic                                    alu_issue_valid,
  output backend_pkg::op_t                        alu_op,
  output logic [backend_pkg::PRF_INDEX_WIDTH-1:0] alu_rd,
  output logic [backend_pkg::DATA_WIDTH-1:0]      alu_imm,
  output logic [backend_pkg::TAG_WIDTH-1:0]       alu_tag,
  output logic [backend_pkg::PRF_INDEX_WIDTH-1:0] alu_rs1_index,
  output logic [backend_pkg::PRF_INDEX_WIDTH-1:0] alu_rs2_index,
  output logic                                    mul_issue_valid,
  output backend_pkg::op_t                        mul_op,
  output logic [backend_pkg::PRF_INDEX_WIDTH-1:0] mul_rd,
  output logic [backend_pkg::TAG_WIDTH-1:0]       mul_tag,
  output logic [backend_pkg::PRF_INDEX_WIDTH-1:0] mul_rs1_index,
  output logic [backend_pkg::PRF_INDEX_WIDTH-1:0] mul_rs2_index
);

  localparam int SEL_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(IQ_DEPTH + 1);

  typedef struct packed {
    backend_pkg::op_t                        op;
    logic [backend_pkg::PRF_INDEX_WIDTH-1:0] rs1;
    logic [backend_pkg::PRF_INDEX_WIDTH-1:0] rs2;
    logic [backend_pkg::PRF_INDEX_WIDTH-1:0] rd;
    logic [backend_pkg::DATA_WIDTH-1:0]      imm;
    logic [backend_pkg::TAG_WIDTH-1:0]       tag;
  } slot_t;

  // slot 0 always holds the oldest micro-op
  slot_t [IQ_DEPTH-1:0] slot_q;
  slot_t [IQ_DEPTH-1:0] slot_next;
  logic  [CNT_W-1:0]    count_q;
  logic  [CNT_W-1:0]    count_next;
  logic                 full;
  logic                 capture;
  logic  [IQ_DEPTH-1:0] slot_ready;
  logic  [SEL_W-1:0]    alu_sel;
  logic  [SEL_W-1:0]    mul_sel;

  assign full = (count_q == IQ_DEPTH);
  // take the micro-op on the edge that raises ack
  assign capture = dispatch_req && !dispatch_ack && !full;
  assign set_valid = capture;
  assign set_index = dispatch_rd;

  // wakeup reads the scoreboard live and li needs no sources
  always_comb begin
    for (int i = 0; i < IQ_DEPTH; i++) begin
      slot_ready[i] = (i < count_q) && ((slot_q[i].op == backend_pkg::li) ||
                      (!busy_vector[slot_q[i].rs1] && !busy_vector[slot_q[i].rs2]));
    end
  end

  // oldest ready slot per pipe
  always_comb begin
    alu_issue_valid = 1'b0;
    mul_issue_valid = 1'b0;
    alu_sel = '0;
    mul_sel = '0;
    for (int i = 0; i < IQ_DEPTH; i++) begin
      if (slot_ready[i]) begin
        if (backend_pkg::is_mul_op(slot_q[i].op)) begin
          if (!mul_issue_valid) begin
            mul_issue_valid = 1'b1;
            mul_sel = SEL_W'(i);
          end
        end else if (!alu_issue_valid) begin
          alu_issue_valid = 1'b1;
          alu_sel = SEL_W'(i);
        end
      end
    end
  end

  assign alu_op        = slot_q[alu_sel].op;
  assign alu_rd        = slot_q[alu_sel].rd;
  assign alu_imm       = slot_q[alu_sel].imm;
  assign alu_tag       = slot_q[alu_sel].tag;
  assign alu_rs1_index = slot_q[alu_sel].rs1;
  assign alu_rs2_index = slot_q[alu_sel].rs2;
  assign mul_op        = slot_q[mul_sel].op;
  assign mul_rd        = slot_q[mul_sel].rd;
  assign mul_tag       = slot_q[mul_sel].tag;
  assign mul_rs1_index = slot_q[mul_sel].rs1;
  assign mul_rs2_index = slot_q[mul_sel].rs2;

  // survivors compact toward slot 0 with the new entry behind them
  always_comb begin
    int n;
    n = 0;
    slot_next = slot_q;
    for (int i = 0; i < IQ_DEPTH; i++) begin
      if ((i < count_q) && !(alu_issue_valid && (alu_sel == i)) &&
          !(mul_issue_valid && (mul_sel == i))) begin
        slot_next[n] = slot_q[i];
        n++;
      end
    end
    if (capture) begin
      slot_next[n] = '{dispatch_op, dispatch_rs1, dispatch_rs2, dispatch_rd,
                       dispatch_imm, dispatch_tag};
      n++;
    end
    count_next = CNT_W'(n);
  end

  always_ff @(posedge clock) begin
    slot_q <= slot_next;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
      dispatch_ack <= 1'b0;
    end else begin
      count_q <= count_next;
      if (capture) begin
        dispatch_ack <= 1'b1;
      end else if (!dispatch_req) begin
        dispatch_ack <= 1'b0;
      end
    end
  end

  ack_needs_req: assert property (
    @(posedge clock) disable iff (reset)
    $rose(dispatch_ack) |-> $past(dispatch_req)
  );

  // a capture into a full queue would push the count past the slot count
  no_capture_full: assert property (
    @(posedge clock) disable iff (reset)
    count_q <= CNT_W'(IQ_DEPTH)
  );

endmodule

// File: src/mul_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiply pipe
// MUL_STAGES deep, low word of the product, one new
// op accepted every cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mul_pipe #(
  parameter int MUL_STAGES = 3
) (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    issue_valid,
  input  backend_pkg::op_t                        op,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] rd,
  input  logic [backend_pkg::TAG_WIDTH-1:0]       tag,
  input  logic [backend_pkg::DATA_WIDTH-1:0]      src1,
  input  logic [backend_pkg::DATA_WIDTH-1:0]      src2,
  output logic                                    out_valid,
  output logic [backend_pkg::PRF_INDEX_WIDTH-1:0] out_rd,
  output logic [backend_pkg::TAG_WIDTH-1:0]       out_tag,
  output logic [backend_pkg::DATA_WIDTH-1:0]      out_data
);

  logic [MUL_STAGES-1:0]                                     valid_q;
  logic [MUL_STAGES-1:0][backend_pkg::PRF_INDEX_WIDTH-1:0]   rd_q;
  logic [MUL_STAGES-1:0][backend_pkg::TAG_WIDTH-1:0]         tag_q;
  logic [MUL_STAGES-1:0][backend_pkg::DATA_WIDTH-1:0]        prod_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[MUL_STAGES-2:0], issue_valid};
    end
  end

  // stage 0 takes the low word, later stages carry it
  always_ff @(posedge clock) begin
    rd_q[0]   <= rd;
    tag_q[0]  <= tag;
    prod_q[0] <= backend_pkg::DATA_WIDTH'(src1 * src2);
    for (int s = 1; s < MUL_STAGES; s++) begin
      rd_q[s]   <= rd_q[s-1];
      tag_q[s]  <= tag_q[s-1];
      prod_q[s] <= prod_q[s-1];
    end
  end

  assign out_valid = valid_q[MUL_STAGES-1];
  assign out_rd    = rd_q[MUL_STAGES-1];
  assign out_tag   = tag_q[MUL_STAGES-1];
  assign out_data  = prod_q[MUL_STAGES-1];

  // the queue routes only multiplies here
  mul_only: assert property (
    @(posedge clock) disable iff (reset)
    issue_valid |-> backend_pkg::is_mul_op(op)
  );

endmodule

// File: src/prf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// physical register file
// four asynchronous reads, two synchronous writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module prf (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0]      rd_index_a1,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0]      rd_index_a2,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0]      rd_index_m1,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0]      rd_index_m2,
  output logic [backend_pkg::DATA_WIDTH-1:0]           rd_data_a1,
  output logic [backend_pkg::DATA_WIDTH-1:0]           rd_data_a2,
  output logic [backend_pkg::DATA_WIDTH-1:0]           rd_data_m1,
  output logic [backend_pkg::DATA_WIDTH-1:0]           rd_data_m2,
  input  logic [1:0]                                   wr_en,
  input  logic [1:0][backend_pkg::PRF_INDEX_WIDTH-1:0] wr_index,
  input  logic [1:0][backend_pkg::DATA_WIDTH-1:0]      wr_data
);

  logic [backend_pkg::PRF_SIZE-1:0][backend_pkg::DATA_WIDTH-1:0] regs;

  // all registers read zero after reset
  always_ff @(posedge clock) begin
    if (reset) begin
      regs <= '0;
    end else begin
      for (int w = 0; w < 2; w++) begin
        if (wr_en[w]) begin
          regs[wr_index[w]] <= wr_data[w];
        end
      end
    end
  end

  assign rd_data_a1 = regs[rd_index_a1];
  assign rd_data_a2 = regs[rd_index_a2];
  assign rd_data_m1 = regs[rd_index_m1];
  assign rd_data_m2 = regs[rd_index_m2];

  // alu and multiply writebacks come from distinct renamed destinations
  write_ports_distinct: assert property (
    @(posedge clock) disable iff (reset)
    (wr_en == 2'b11) |-> (wr_index[0] != wr_index[1])
  );

endmodule

// File: src/scoreboard.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scoreboard
// one busy bit per physical register, set at
// dispatch and cleared by either writeback port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scoreboard (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          set_valid,
  input  logic [backend_pkg::PRF_INDEX_WIDTH-1:0]       set_index,
  input  logic [1:0]                                    clear_valid,
  input  logic [1:0][backend_pkg::PRF_INDEX_WIDTH-1:0]  clear_index,
  output logic [backend_pkg::PRF_SIZE-1:0]              busy_vector
);

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_vector <= '0;
    end else begin
      // renamed destinations never collide, so clear and set are independent
      for (int i = 0; i < 2; i++) begin
        if (clear_valid[i]) begin
          busy_vector[clear_index[i]] <= 1'b0;
        end
      end
      if (set_valid) begin
        busy_vector[set_index] <= 1'b1;
      end
    end
  end

  // a new producer must own an idle register
  set_idle_reg: assert property (
    @(posedge clock) disable iff (reset)
    set_valid |-> !busy_vector[set_index]
  );

  // writeback only retires a register that a dispatch marked busy
  clear_alu_busy: assert property (
    @(posedge clock) disable iff (reset)
    clear_valid[0] |-> busy_vector[clear_index[0]]
  );

  clear_mul_busy: assert property (
    @(posedge clock) disable iff (reset)
    clear_valid[1] |-> busy_vector[clear_index[1]]
  );

endmodule

// File: testbench/result_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result checker
// compares both result channels against a table of
// expected data by tag, and watches reset and dispatch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module result_checker #(
  parameter int PATTERN_COUNT = 28
) (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               dispatch_req,
  input  logic                               dispatch_ack,
  input  logic                               result_alu_valid,
  input  logic [backend_pkg::TAG_WIDTH-1:0]  result_alu_tag,
  input  logic [backend_pkg::DATA_WIDTH-1:0] result_alu_data,
  input  logic                               result_mul_valid,
  input  logic [backend_pkg::TAG_WIDTH-1:0]  result_mul_tag,
  input  logic [backend_pkg::DATA_WIDTH-1:0] result_mul_data,
  output int                                 mismatch_errors,
  output int                                 other_errors,
  output int                                 results_seen
);

  localparam int FIELD_COUNT = 7;
  localparam int TAG_COUNT = 2 ** backend_pkg::TAG_WIDTH;

  logic [31:0]                        pattern_mem [0:PATTERN_COUNT*FIELD_COUNT-1];
  logic [backend_pkg::DATA_WIDTH-1:0] expected [0:TAG_COUNT-1];
  backend_pkg::op_t                   tag_op [0:TAG_COUNT-1];
  bit                                 known [0:TAG_COUNT-1];
  int                                 seen [0:TAG_COUNT-1];
  int                                 mismatch_count;
  int                                 other_count;
  int                                 accepted;
  int                                 wait_run;
  int                                 longest_wait;
  logic                               reset_q;

  assign mismatch_errors = mismatch_count;
  assign other_errors = other_count;

  // expected data per tag from the last column
  initial begin
    int tag;
    for (int t = 0; t < TAG_COUNT; t++) begin
      known[t] = 1'b0;
      seen[t] = 0;
      expected[t] = '0;
      tag_op[t] = backend_pkg::li;
    end
    mismatch_count = 0;
    other_count = 0;
    accepted = 0;
    wait_run = 0;
    longest_wait = 0;
    reset_q = 1'b0;
    results_seen = 0;
    $readmemh("testbench/uop_patterns.txt", pattern_mem);
    for (int i = 0; i < PATTERN_COUNT; i++) begin
      tag = pattern_mem[i * FIELD_COUNT];
      tag_op[tag] = backend_pkg::op_t'(pattern_mem[i * FIELD_COUNT + 1][2:0]);
      expected[tag] = pattern_mem[i * FIELD_COUNT + 6];
      known[tag] = 1'b1;
    end
  end

  task automatic check_result(input string channel, input bit mul_channel,
                              input logic [backend_pkg::TAG_WIDTH-1:0] tag,
                              input logic [backend_pkg::DATA_WIDTH-1:0] data);
    if (!known[tag]) begin
      $display("unknown tag %h returned on %s", tag, channel);
      other_count++;
    end else begin
      seen[tag]++;
      if (seen[tag] > 1) begin
        $display("tag %h returned more than once", tag);
        other_count++;
      end else begin
        accepted++;
      end
      // multiplies leave on the multiply channel and everything else on the alu
      if ((tag_op[tag] == backend_pkg::mul) != mul_channel) begin
        $display("tag %h came back on the wrong channel %s", tag, channel);
        other_count++;
      end
      if (data !== expected[tag]) begin
        $display("mismatch: %s_data tag %h expected %h got %h",
                 channel, tag, expected[tag], data);
        mismatch_count++;
      end
    end
  endtask

  task automatic final_audit();
    for (int t = 0; t < TAG_COUNT; t++) begin
      if (known[t] && (seen[t] == 0)) begin
        $display("tag %h never returned a result", 5'(t));
        other_count++;
      end
    end
    if (longest_wait < 2) begin
      $display("dispatch ack was never held back by a full queue");
      other_count++;
    end
  endtask

  always @(posedge clock) begin
    // outputs must be low once reset has been applied, and one cycle after
    if (reset_q) begin
      if ((dispatch_ack !== 1'b0) || (result_alu_valid !== 1'b0) ||
          (result_mul_valid !== 1'b0)) begin
        $display("ack or a result valid was not low around reset");
        other_count++;
      end
    end else if (!reset && $isunknown({dispatch_ack, result_alu_valid, result_mul_valid})) begin
      $display("ack or a result valid is unknown after reset");
      other_count++;
    end
    reset_q <= reset;
    if (!reset) begin
      if (result_alu_valid === 1'b1) begin
        check_result("result_alu", 1'b0, result_alu_tag, result_alu_data);
      end
      if (result_mul_valid === 1'b1) begin
        check_result("result_mul", 1'b1, result_mul_tag, result_mul_data);
      end
      // a free slot answers req after one cycle and a longer wait means full
      if ((dispatch_req === 1'b1) && (dispatch_ack === 1'b0)) begin
        wait_run++;
      end else begin
        wait_run = 0;
      end
      if (wait_run > longest_wait) begin
        longest_wait = wait_run;
      end
    end
    results_seen <= accepted;
  end

endmodule

// File: testbench/tb_core_backend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// back end testbench
// replays micro-ops from the pattern file through
// the four-phase dispatch port and waits for results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_core_backend;

  localparam int PATTERN_COUNT = 28;
  localparam int FIELD_COUNT = 7;
  // small queue and deep multiplier so the dependent burst backs up
  localparam int IQ_DEPTH = 4;
  localparam int MUL_STAGES = 20;
  localparam int TIMEOUT_CYCLES = 40 * PATTERN_COUNT + 100;

  logic                                    clock;
  logic                                    reset;
  logic                                    dispatch_req;
  backend_pkg::op_t                        dispatch_op;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] dispatch_rs1;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] dispatch_rs2;
  logic [backend_pkg::PRF_INDEX_WIDTH-1:0] dispatch_rd;
  logic [backend_pkg::DATA_WIDTH-1:0]      dispatch_imm;
  logic [backend_pkg::TAG_WIDTH-1:0]       dispatch_tag;
  logic                                    dispatch_ack;
  logic                                    result_alu_valid;
  logic [backend_pkg::TAG_WIDTH-1:0]       result_alu_tag;
  logic [backend_pkg::DATA_WIDTH-1:0]      result_alu_data;
  logic                                    result_mul_valid;
  logic [backend_pkg::TAG_WIDTH-1:0]       result_mul_tag;
  logic [backend_pkg::DATA_WIDTH-1:0]      result_mul_data;
  int                                      mismatch_errors;
  int                                      other_errors;
  int                                      results_seen;
  int                                      cycle_count;

  // pattern columns are tag, op, rs1, rs2, rd, imm and expected
  logic [31:0] pattern_mem [0:PATTERN_COUNT*FIELD_COUNT-1];

  always #2 clock = ~clock;

  core_backend #(
    .IQ_DEPTH   (IQ_DEPTH),
    .MUL_STAGES (MUL_STAGES)
  ) UUT (
    .clock            (clock),
    .reset            (reset),
    .dispatch_req     (dispatch_req),
    .dispatch_op      (dispatch_op),
    .dispatch_rs1     (dispatch_rs1),
    .dispatch_rs2     (dispatch_rs2),
    .dispatch_rd      (dispatch_rd),
    .dispatch_imm     (dispatch_imm),
    .dispatch_tag     (dispatch_tag),
    .dispatch_ack     (dispatch_ack),
    .result_alu_valid (result_alu_valid),
    .result_alu_tag   (result_alu_tag),
    .result_alu_data  (result_alu_data),
    .result_mul_valid (result_mul_valid),
    .result_mul_tag   (result_mul_tag),
    .result_mul_data  (result_mul_data)
  );

  result_checker #(.PATTERN_COUNT(PATTERN_COUNT)) result_check (
    .clock            (clock),
    .reset            (reset),
    .dispatch_req     (dispatch_req),
    .dispatch_ack     (dispatch_ack),
    .result_alu_valid (result_alu_valid),
    .result_alu_tag   (result_alu_tag),
    .result_alu_data  (result_alu_data),
    .result_mul_valid (result_mul_valid),
    .result_mul_tag   (result_mul_tag),
    .result_mul_data  (result_mul_data),
    .mismatch_errors  (mismatch_errors),
    .other_errors     (other_errors),
    .results_seen     (results_seen)
  );

  // one full four-phase transfer from the current edge
  task automatic dispatch_uop(input int index);
    int base;
    base = index * FIELD_COUNT;
    dispatch_tag <= pattern_mem[base][backend_pkg::TAG_WIDTH-1:0];
    dispatch_op  <= backend_pkg::op_t'(pattern_mem[base + 1][2:0]);
    dispatch_rs1 <= pattern_mem[base + 2][backend_pkg::PRF_INDEX_WIDTH-1:0];
    dispatch_rs2 <= pattern_mem[base + 3][backend_pkg::PRF_INDEX_WIDTH-1:0];
    dispatch_rd  <= pattern_mem[base + 4][backend_pkg::PRF_INDEX_WIDTH-1:0];
    dispatch_imm <= pattern_mem[base + 5];
    dispatch_req <= 1'b1;
    do @(posedge clock); while (dispatch_ack !== 1'b1);
    dispatch_req <= 1'b0;
    do @(posedge clock); while (dispatch_ack !== 1'b0);
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: only %0d of %0d results after %0d cycles",
               results_seen, PATTERN_COUNT, cycle_count);
      result_check.final_audit();
      @(negedge clock);
      $display("errors: %0d mismatch, %0d other, 1 timeout", mismatch_errors, other_errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    int unsigned seed;
    int gap;
    clock = 1'b0;
    reset = 1'b1;
    dispatch_req = 1'b0;
    dispatch_op = backend_pkg::li;
    dispatch_rs1 = '0;
    dispatch_rs2 = '0;
    dispatch_rd = '0;
    dispatch_imm = '0;
    dispatch_tag = '0;
    cycle_count = 0;
    seed = 65;
    gap = $urandom(seed);
    $readmemh("testbench/uop_patterns.txt", pattern_mem);
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < PATTERN_COUNT; i++) begin
      gap = $urandom % 4;
      repeat (gap) @(posedge clock);
      dispatch_uop(i);
    end
    while (results_seen < PATTERN_COUNT) begin
      @(posedge clock);
    end
    result_check.final_audit();
    @(posedge clock);
    $display("errors: %0d mismatch, %0d other, 0 timeout", mismatch_errors, other_errors);
    if ((mismatch_errors == 0) && (other_errors == 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: testbench/uop_patterns.txt
// tag op rs1 rs2 rd imm expected, all hex
// op: 0 li, 1 add, 2 sub, 3 and, 4 or, 5 xor, 6 mul
00 0 00 00 01 12345678 12345678
01 0 00 00 02 0000f0f0 0000f0f0
02 1 01 02 03 00000000 12354768
03 2 02 01 04 00000000 edcc9a78
04 3 01 02 05 00000000 00005070
05 4 01 02 06 00000000 1234f6f8
06 5 01 02 07 00000000 1234a688
07 0 00 00 08 00010001 00010001
08 0 00 00 09 0000ffff 0000ffff
09 6 08 09 0a 00000000 ffffffff
0a 6 01 09 0b 00000000 4443a988
0b 6 02 02 0c 00000000 e2c2e100
0c 1 0a 08 0d 00000000 00010000
0d 6 0d 02 0e 00000000 f0f00000
0e 5 0e 0b 0f 00000000 b4b3a988
0f 2 0f 03 10 00000000 a27e6220
10 6 09 09 11 00000000 fffe0001
11 0 00 00 12 5a5aa5a5 5a5aa5a5
12 4 12 05 13 00000000 5a5af5f5
13 6 09 08 14 00000000 ffffffff
14 6 14 08 15 00000000 fffeffff
15 1 15 01 16 00000000 12335677
16 3 15 02 17 00000000 0000f0f0
17 5 15 09 18 00000000 fffe0000
18 6 15 15 19 00000000 00020001
19 2 15 08 1a 00000000 fffdfffe
1a 4 15 12 1b 00000000 fffeffff
1b 6 15 0d 1c 00000000 ffff0000

// File: verilog.f
src/backend_pkg.sv
src/scoreboard.sv
src/issue_queue.sv
src/prf.sv
src/alu_pipe.sv
src/mul_pipe.sv
src/core_backend.sv
testbench/result_checker.sv
testbench/tb_core_backend.sv
